//--- logic/fc_pkg.sv
/*
  Shared widths and constants for the fully connected row.
  The multiplier core is built for 8x8 signed operands only.
  A run holds at most 2**idx_w classes.
*/
package fc_pkg;

  // Datapath widths
  localparam int data_w = 8;
  localparam int lanes  = 4;
  localparam int word_w = data_w * lanes;
  localparam int prod_w = 2 * data_w;
  localparam int acc_w  = 28;

  // Pipeline depth, counted in register stages
  localparam int mult_stages = 8;
  localparam int mac_latency = mult_stages + 1;

  // Requantization
  localparam int bias_shift = 6;
  localparam int out_max    = 127;

  // Argmax
  localparam int idx_w = 4;
  localparam logic signed [data_w-1:0] max_init = -8'sd128;

endpackage

//--- logic/cla_adder.sv
/*
  Carry-lookahead adder made of 4-bit lookahead blocks.
  width must be a multiple of 4.
  With sub high the result is b - a and carry means b >= a (unsigned).
  Purely combinational.
*/
`timescale 1ns/1ps

module cla_adder #(
  parameter int width = 28
) (
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  input  logic             sub,
  output logic [width-1:0] sum,
  output logic             carry
);

  localparam int blocks = width / 4;

  logic [width-1:0]  a_eff;
  logic [width-1:0]  p;
  logic [width-1:0]  g;
  logic [width-1:0]  bit_c;
  logic [blocks:0]   blk_c;

  if (width % 4 != 0) begin : g_bad_width
    $error("cla_adder width %0d is not a multiple of 4", width);
  end

  // Invert a and inject a carry for subtraction
  assign a_eff    = sub ? ~a : a;
  assign p        = a_eff ^ b;
  assign g        = a_eff & b;
  assign blk_c[0] = sub;

  for (genvar i = 0; i < blocks; i++) begin : g_blk
    logic [3:0] bp;
    logic [3:0] bg;
    logic       grp_p;
    logic       grp_g;

    assign bp = p[4*i +: 4];
    assign bg = g[4*i +: 4];

    // Lookahead inside the block
    assign bit_c[4*i]   = blk_c[i];
    assign bit_c[4*i+1] = bg[0] | (bp[0] & blk_c[i]);
    assign bit_c[4*i+2] = bg[1] | (bp[1] & bg[0]) | (bp[1] & bp[0] & blk_c[i]);
    assign bit_c[4*i+3] = bg[2] | (bp[2] & bg[1]) | (bp[2] & bp[1] & bg[0])
                        | (bp[2] & bp[1] & bp[0] & blk_c[i]);

    // Group terms feed the block carry chain
    assign grp_p      = &bp;
    assign grp_g      = bg[3] | (bp[3] & bg[2]) | (bp[3] & bp[2] & bg[1])
                      | (bp[3] & bp[2] & bp[1] & bg[0]);
    assign blk_c[i+1] = grp_g | (grp_p & blk_c[i]);
  end

  assign sum   = p ^ bit_c;
  assign carry = blk_c[blocks];

endmodule

//--- logic/mult_pipe.sv
/*
  Eight-stage signed 8x8 multiplier.
  Works on magnitudes and restores the sign in the last stage.
  Accepts a new operand pair every cycle; only the valid chain is reset.
*/
`timescale 1ns/1ps

module mult_pipe (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic [fc_pkg::data_w-1:0] a,
  input  logic [fc_pkg::data_w-1:0] b,
  input  logic                      in_valid,
  input  logic [1:0]                in_tag,
  output logic [fc_pkg::prod_w-1:0] prod,
  output logic                      out_valid,
  output logic [1:0]                out_tag
);

  import fc_pkg::*;

  logic [7:0]  a_mag;
  logic [7:0]  b_mag;
  logic [7:0]  s1_pp [8];
  logic [5:0]  s2_lo [4];
  logic [2:0]  s2_hi_e [4];
  logic [3:0]  s2_hi_o [4];
  logic [9:0]  s3_sum [4];
  logic [7:0]  s4_lo [2];
  logic [2:0]  s4_hi_e [2];
  logic [4:0]  s4_hi_o [2];
  logic [11:0] s5_sum [2];
  logic [9:0]  s6_lo;
  logic [2:0]  s6_hi_e;
  logic [6:0]  s6_hi_o;
  logic [15:0] s7_mag;

  logic [mult_stages-1:0] vld_sr;
  logic [mult_stages-2:0] sign_sr;
  logic [1:0]             tag_sr [mult_stages];

  always_comb begin
    a_mag = a[7] ? (~a + 8'd1) : a;
    b_mag = b[7] ? (~b + 8'd1) : b;
  end

  //////////////////////////////////////////////////
  // Stages 1 to 3, gated partial products, shift 1
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int i = 0; i < 8; i++) begin
      s1_pp[i] <= b_mag[i] ? a_mag : 8'd0;
    end
    for (int k = 0; k < 4; k++) begin
      s2_lo[k]   <= 6'(s1_pp[2*k][4:0] + {s1_pp[2*k+1][3:0], 1'b0});
      s2_hi_e[k] <= s1_pp[2*k][7:5];
      s2_hi_o[k] <= s1_pp[2*k+1][7:4];
      s3_sum[k]  <= {5'(s2_hi_e[k] + s2_hi_o[k] + s2_lo[k][5]), s2_lo[k][4:0]};
    end
  end

  //////////////////////////////////////////////////
  // Stages 4 and 5, shift 2
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int k = 0; k < 2; k++) begin
      s4_lo[k]   <= 8'(s3_sum[2*k][6:0] + {s3_sum[2*k+1][4:0], 2'b00});
      s4_hi_e[k] <= s3_sum[2*k][9:7];
      s4_hi_o[k] <= s3_sum[2*k+1][9:5];
      s5_sum[k]  <= {5'(s4_hi_e[k] + s4_hi_o[k] + s4_lo[k][7]), s4_lo[k][6:0]};
    end
  end

  //////////////////////////////////////////////////
  // Stages 6 to 8, shift 4 and sign restore
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    s6_lo   <= 10'(s5_sum[0][8:0] + {s5_sum[1][4:0], 4'b0000});
    s6_hi_e <= s5_sum[0][11:9];
    s6_hi_o <= s5_sum[1][11:5];
    s7_mag  <= {7'(s6_hi_e + s6_hi_o + s6_lo[9]), s6_lo[8:0]};
    prod    <= sign_sr[mult_stages-2] ? (~s7_mag + 16'd1) : s7_mag;
  end

  // Sign and tag ride along with the data
  always_ff @(posedge clk) begin
    sign_sr   <= {sign_sr[mult_stages-3:0], a[7] ^ b[7]};
    tag_sr[0] <= in_tag;
    for (int k = 1; k < mult_stages; k++) begin
      tag_sr[k] <= tag_sr[k-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[mult_stages-2:0], in_valid};
    end
  end

  assign out_valid = vld_sr[mult_stages-1];
  assign out_tag   = tag_sr[mult_stages-1];

endmodule

//--- logic/mac_pe.sv
/*
  One MAC lane: pipelined multiplier and a 28-bit accumulator.
  A product tagged first restarts the sum, others add to it.
  The accumulator holds between groups and has no reset.
*/
`timescale 1ns/1ps

module mac_pe (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic [fc_pkg::data_w-1:0] feat,
  input  logic [fc_pkg::data_w-1:0] weight,
  input  logic                      in_valid,
  input  logic                      in_first,
  input  logic                      in_last,
  output logic [fc_pkg::acc_w-1:0]  acc,
  output logic                      acc_valid,
  output logic                      acc_last
);

  import fc_pkg::*;

  logic [prod_w-1:0] prod;
  logic              prod_valid;
  logic [1:0]        prod_tag;
  logic [acc_w-1:0]  prod_ext;
  logic [acc_w-1:0]  acc_base;
  logic [acc_w-1:0]  acc_next;

  // Tag bit 0 is first, bit 1 is last
  mult_pipe u_mult (
    .clk       (clk),
    .rstn      (rstn),
    .a         (feat),
    .b         (weight),
    .in_valid  (in_valid),
    .in_tag    ({in_last, in_first}),
    .prod      (prod),
    .out_valid (prod_valid),
    .out_tag   (prod_tag)
  );

  assign prod_ext = {{(acc_w-prod_w){prod[prod_w-1]}}, prod};
  assign acc_base = prod_tag[0] ? '0 : acc;

  cla_adder #(.width(acc_w)) u_acc_add (
    .a     (prod_ext),
    .b     (acc_base),
    .sub   (1'b0),
    .sum   (acc_next),
    .carry ()
  );

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      acc <= acc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      acc_valid <= 1'b0;
      acc_last  <= 1'b0;
    end else begin
      acc_valid <= prod_valid;
      acc_last  <= prod_valid & prod_tag[1];
    end
  end

endmodule

//--- logic/requant.sv
/*
  Bias add and clamp of one lane, purely combinational.
  The bias is a signed byte with bias_shift fractional bits.
  Output range is 0..out_max.
*/
`timescale 1ns/1ps

module requant (
  input  logic [fc_pkg::acc_w-1:0]  acc,
  input  logic [fc_pkg::data_w-1:0] bias,
  output logic [fc_pkg::data_w-1:0] q
);

  import fc_pkg::*;

  // Lowest bit that no longer fits in the 7-bit result
  localparam int top_lsb = bias_shift + data_w - 1;

  logic [acc_w-1:0] bias_ext;
  logic [acc_w-1:0] sum;

  assign bias_ext = {{(acc_w-data_w-bias_shift){bias[data_w-1]}}, bias, {bias_shift{1'b0}}};

  cla_adder #(.width(acc_w)) u_bias_add (
    .a     (bias_ext),
    .b     (acc),
    .sub   (1'b0),
    .sum   (sum),
    .carry ()
  );

  always_comb begin
    if (sum[acc_w-1]) begin
      q = '0;
    end else if (|sum[acc_w-2:top_lsb]) begin
      q = data_w'(out_max);
    end else begin
      q = {1'b0, sum[top_lsb-1:bias_shift]};
    end
  end

endmodule

//--- logic/argmax_scan.sv
/*
  Running argmax over the words of one run, one lane per cycle.
  Lane 0 is compared on the arrival cycle, so max_valid follows in 4.
  A tie goes to the later class. start must not hit a busy scan.
*/
`timescale 1ns/1ps

module argmax_scan (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      start,
  input  logic [fc_pkg::word_w-1:0] word,
  input  logic                      word_valid,
  output logic [fc_pkg::idx_w-1:0]  max_idx,
  output logic                      max_valid
);

  import fc_pkg::*;

  logic [word_w-1:0]        word_q;
  logic                     busy;
  logic [$clog2(lanes)-1:0] lane_q;
  logic [$clog2(lanes)-1:0] cur_lane;
  logic [idx_w-2:0]         grp_q;
  logic [data_w-1:0]        max_val;
  logic [data_w-1:0]        cur_val;
  logic [idx_w-1:0]         cand_idx;
  logic                     ge;

  assign cur_lane = busy ? lane_q : '0;
  assign cur_val  = busy ? word_q[lane_q*data_w +: data_w] : word[data_w-1:0];
  assign cand_idx = idx_w'(grp_q * lanes + cur_lane);

  // Signed compare as unsigned with flipped sign bits
  cla_adder #(.width(data_w)) u_cmp (
    .a     (max_val ^ {1'b1, {(data_w-1){1'b0}}}),
    .b     (cur_val ^ {1'b1, {(data_w-1){1'b0}}}),
    .sub   (1'b1),
    .sum   (),
    .carry (ge)
  );

  always_ff @(posedge clk) begin
    if (word_valid) begin
      word_q <= word;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy      <= 1'b0;
      lane_q    <= '0;
      grp_q     <= '0;
      max_val   <= max_init;
      max_idx   <= '0;
      max_valid <= 1'b0;
    end else begin
      max_valid <= 1'b0;
      if (start) begin
        grp_q   <= '0;
        max_val <= max_init;
        max_idx <= '0;
      end else if (word_valid || busy) begin
        if (ge) begin
          max_val <= cur_val;
          max_idx <= cand_idx;
        end
        if (cur_lane == lanes - 1) begin
          busy      <= 1'b0;
          lane_q    <= '0;
          grp_q     <= grp_q + 1'b1;
          max_valid <= 1'b1;
        end else begin
          busy   <= 1'b1;
          lane_q <= cur_lane + 1'b1;
        end
      end
    end
  end

  // Groups shorter than four products would overrun the scan
  a_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
    word_valid |-> !busy);

  a_grp_range: assert property (@(posedge clk) disable iff (!rstn)
    word_valid |-> grp_q < ((1 << idx_w) / lanes));

endmodule

//--- logic/fc_row.sv
/*
  Compute row of the FC engine: four MAC lanes, requant and argmax.
  No back-pressure; the consumer must take every out_valid.
  out_valid follows the in_last sample by mac_latency + 1 cycles.
  Word lanes are packed with lane 0 in the low byte.
*/
`timescale 1ns/1ps

module fc_row (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      start,
  input  logic                      in_valid,
  input  logic                      in_first,
  input  logic                      in_last,
  input  logic [fc_pkg::data_w-1:0] feat_in,
  input  logic [fc_pkg::word_w-1:0] weight_in,
  input  logic [fc_pkg::word_w-1:0] bias_in,
  output logic [fc_pkg::word_w-1:0] out_word,
  output logic                      out_valid,
  output logic [fc_pkg::idx_w-1:0]  max_idx,
  output logic                      max_valid
);

  import fc_pkg::*;

  logic [acc_w-1:0]  acc [lanes];
  logic [lanes-1:0]  acc_last;
  logic [word_w-1:0] bias_sr [mac_latency];
  logic [word_w-1:0] q_word;

  //////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////
  for (genvar i = 0; i < lanes; i++) begin : g_lane
    mac_pe u_pe (
      .clk       (clk),
      .rstn      (rstn),
      .feat      (feat_in),
      .weight    (weight_in[i*data_w +: data_w]),
      .in_valid  (in_valid),
      .in_first  (in_first),
      .in_last   (in_last),
      .acc       (acc[i]),
      .acc_valid (),
      .acc_last  (acc_last[i])
    );

    requant u_rq (
      .acc  (acc[i]),
      .bias (bias_sr[mac_latency-1][i*data_w +: data_w]),
      .q    (q_word[i*data_w +: data_w])
    );
  end

  // Bias travels beside the MAC pipe and meets acc_last at the tail
  always_ff @(posedge clk) begin
    bias_sr[0] <= bias_in;
    for (int k = 1; k < mac_latency; k++) begin
      bias_sr[k] <= bias_sr[k-1];
    end
  end

  always_ff @(posedge clk) begin
    if (acc_last[0]) begin
      out_word <= q_word;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= acc_last[0];
    end
  end

  argmax_scan u_argmax (
    .clk        (clk),
    .rstn       (rstn),
    .start      (start),
    .word       (out_word),
    .word_valid (out_valid),
    .max_idx    (max_idx),
    .max_valid  (max_valid)
  );

  a_latency: assert property (@(posedge clk) disable iff (!rstn)
    in_valid && in_last |-> ##(mac_latency + 1) out_valid);

endmodule

//--- tests/tb_fc_row.sv
/*
  Testbench for the FC compute row.
  Stimulus and expected words come from tests/fc_golden.txt.
  Products of a group are driven back to back. Random idle gaps are only
  inserted before groups that allow them.
  A run restarts the argmax only after all pending scans have finished.
*/
`timescale 1ns/1ps

module tb_fc_row;

  import fc_pkg::*;

  localparam time period     = 100;
  localparam int  out_lat    = 10;
  localparam int  scan_lat   = 4;
  localparam int  wait_limit = 200;

  typedef struct packed {
    logic [7:0]        kind;
    logic              first;
    logic              last;
    logic              pack;
    logic [data_w-1:0] feat;
    logic [word_w-1:0] wt;
    logic [word_w-1:0] bias;
  } op_t;

  logic              clk;
  logic              rstn;
  logic              start;
  logic              in_valid;
  logic              in_first;
  logic              in_last;
  logic [data_w-1:0] feat_in;
  logic [word_w-1:0] weight_in;
  logic [word_w-1:0] bias_in;
  logic [word_w-1:0] out_word;
  logic              out_valid;
  logic [idx_w-1:0]  max_idx;
  logic              max_valid;

  op_t               ops [$];
  logic [word_w-1:0] exp_word [$];
  logic [idx_w-1:0]  exp_idx [$];
  time               sample_t [$];
  time               rise_t [$];
  bit                group_bad [64];

  int errors       = 0;
  int timeouts     = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int groups_sent  = 0;
  int groups_done  = 0;

  fc_row u_dut (
    .clk       (clk),
    .rstn      (rstn),
    .start     (start),
    .in_valid  (in_valid),
    .in_first  (in_first),
    .in_last   (in_last),
    .feat_in   (feat_in),
    .weight_in (weight_in),
    .bias_in   (bias_in),
    .out_word  (out_word),
    .out_valid (out_valid),
    .max_idx   (max_idx),
    .max_valid (max_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Golden file parsing
  //////////////////////////////////////////////////
  task automatic load_golden();
    int                fd;
    int                n;
    int                fi;
    int                la;
    int                pa;
    int                ei;
    string             line;
    op_t               op;
    logic [data_w-1:0] ft;
    logic [word_w-1:0] wt;
    logic [word_w-1:0] bs;
    logic [word_w-1:0] ew;
    fd = $fopen("tests/fc_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file tests/fc_golden.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() == 0) continue;
      op = '0;
      case (line.getc(0))
        "S": begin
          op.kind = "S";
          ops.push_back(op);
        end
        "F": begin
          n = $sscanf(line, "F %d %d %d %h %h %h", fi, la, pa, ft, wt, bs);
          if (n != 6) begin
            $display("Malformed feature record in the golden file: %s", line);
            errors++;
          end
          op.kind  = "F";
          op.first = fi[0];
          op.last  = la[0];
          op.pack  = pa[0];
          op.feat  = ft;
          op.wt    = wt;
          op.bias  = bs;
          ops.push_back(op);
        end
        "E": begin
          n = $sscanf(line, "E %h %h", ew, ei);
          if (n != 2) begin
            $display("Malformed expected record in the golden file: %s", line);
            errors++;
          end
          exp_word.push_back(ew);
          exp_idx.push_back(idx_w'(ei));
        end
        default: ;
      endcase
    end
    $fclose(fd);
    if (exp_word.size() == 0) begin
      $display("The golden file holds no expected results");
      errors++;
    end
  endtask

  // Outputs must stay quiet while reset is held
  task automatic check_reset_state();
    bit bad;
    bad = 1'b0;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      @(negedge clk);
      assert (out_valid === 1'b0 && max_valid === 1'b0) else begin
        $display("ERROR %0t: output strobe active during reset", $time);
        errors++;
        bad = 1'b1;
      end
    end
    tests_run++;
    if (bad) tests_failed++;
    $display("Reset state: %s", bad ? "failed" : "passed");
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  task automatic drive_ops();
    op_t op;
    int  gap;
    int  waited;
    foreach (ops[i]) begin
      op = ops[i];
      if (op.kind == "S") begin
        // Idle the inputs and let every pending scan finish before the argmax is cleared
        @(posedge clk);
        in_valid <= 1'b0;
        waited = 0;
        while (groups_done < groups_sent && waited < wait_limit) begin
          @(posedge clk);
          waited++;
        end
        if (groups_done < groups_sent) begin
          $display("Timed out waiting for the scans to finish before start");
          timeouts++;
        end
        @(posedge clk);
        start    <= 1'b1;
        @(posedge clk);
        start    <= 1'b0;
      end else begin
        if (op.first && !op.pack) begin
          gap = int'($urandom % 4);
          repeat (gap) begin
            @(posedge clk);
            in_valid <= 1'b0;
          end
        end
        @(posedge clk);
        in_valid  <= 1'b1;
        in_first  <= op.first;
        in_last   <= op.last;
        feat_in   <= op.feat;
        weight_in <= op.wt;
        bias_in   <= op.bias;
        if (op.last) begin
          // The DUT samples on the following edge
          sample_t.push_back($time + period);
          groups_sent++;
        end
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
    in_first <= 1'b0;
    in_last  <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Output checks
  //////////////////////////////////////////////////
  task automatic check_words();
    int  waited;
    time rise;
    for (int g = 0; g < exp_word.size(); g++) begin
      waited = 0;
      @(negedge clk);
      while (!out_valid && waited < wait_limit) begin
        if (g == 0) begin
          assert (max_valid === 1'b0) else begin
            $display("ERROR %0t: max_valid before the first word", $time);
            errors++;
            group_bad[0] = 1'b1;
          end
        end
        @(negedge clk);
        waited++;
      end
      if (!out_valid) begin
        $display("Timed out waiting for out_valid of group %0d", g);
        timeouts++;
        group_bad[g] = 1'b1;
        rise_t.push_back(0);
      end else begin
        // Edge at which the strobe is first seen high
        rise = $time + period / 2;
        rise_t.push_back(rise);
        assert (out_word === exp_word[g]) else begin
          $display("ERROR %0t: group %0d out_word %h, expected %h",
                   $time, g, out_word, exp_word[g]);
          errors++;
          group_bad[g] = 1'b1;
        end
        if (g < sample_t.size()) begin
          assert (rise == sample_t[g] + out_lat * period) else begin
            $display("ERROR %0t: group %0d out_valid at %0t, expected at %0t",
                     $time, g, rise, sample_t[g] + out_lat * period);
            errors++;
            group_bad[g] = 1'b1;
          end
        end
      end
    end
  endtask

  task automatic check_indices();
    int  waited;
    time rise;
    for (int g = 0; g < exp_idx.size(); g++) begin
      waited = 0;
      @(negedge clk);
      while (!max_valid && waited < wait_limit) begin
        @(negedge clk);
        waited++;
      end
      if (!max_valid) begin
        $display("Timed out waiting for max_valid of group %0d", g);
        timeouts++;
        group_bad[g] = 1'b1;
      end else begin
        rise = $time + period / 2;
        assert (max_idx === exp_idx[g]) else begin
          $display("ERROR %0t: group %0d max_idx %0d, expected %0d",
                   $time, g, max_idx, exp_idx[g]);
          errors++;
          group_bad[g] = 1'b1;
        end
        if (g < rise_t.size() && rise_t[g] != 0) begin
          assert (rise == rise_t[g] + scan_lat * period) else begin
            $display("ERROR %0t: group %0d max_valid at %0t, expected at %0t",
                     $time, g, rise, rise_t[g] + scan_lat * period);
            errors++;
            group_bad[g] = 1'b1;
          end
        end
      end
      groups_done++;
      tests_run++;
      if (group_bad[g]) tests_failed++;
      $display("Group %0d: %s", g, group_bad[g] ? "failed" : "passed");
    end
  endtask

  initial begin
    void'($urandom(83));
    rstn      = 1'b0;
    start     = 1'b0;
    in_valid  = 1'b0;
    in_first  = 1'b0;
    in_last   = 1'b0;
    feat_in   = '0;
    weight_in = '0;
    bias_in   = '0;
    load_golden();
    check_reset_state();
    @(posedge clk);
    rstn <= 1'b1;
    fork
      drive_ops();
      check_words();
      check_indices();
    join
    $display("Tests run %0d, failed %0d, errors %0d, timeouts %0d",
             tests_run, tests_failed, errors, timeouts);
    if (errors == 0 && timeouts == 0 && tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- tests/fc_golden.txt
# F first last pack feat weights bias (hex words, lane 0 low); pack 1 = no idle before group
# S opens a run; E out_word max_idx (hex) is the result of the group above
S
F 1 0 0 80 FF000A80 00000000
F 0 0 0 10 7FF81400 00000000
F 0 0 0 F0 00031E00 00000000
F 0 1 0 05 80640000 28FA1E00
E 3F00077F 0
F 1 0 0 01 00807F64 00000000
F 0 0 0 02 00807F00 00000000
F 0 0 0 03 00807F00 00000000
F 0 1 0 04 CE807F00 03157F32
E 00017F33 5
F 1 0 1 7F 00000001 00000000
F 0 0 0 01 00000500 00000000
F 0 0 0 01 00000500 00000000
F 0 1 0 01 00000500 00000A7E
E 00000A7F 8
S
F 1 0 0 02 0032FB0A 00000000
F 0 0 0 02 0032FB0A 00000000
F 0 0 0 02 0032FB0A 00000000
F 0 1 0 02 0032FB0A 06000100
E 06060001 3
F 1 0 1 81 00010080 00000000
F 0 0 0 81 00000080 00000000
F 0 0 0 7F 00000100 00000000
F 0 1 0 7F 02000100 0002FD00
E 0300007F 4

//--- src.f
logic/fc_pkg.sv
logic/cla_adder.sv
logic/mult_pipe.sv
logic/mac_pe.sv
logic/requant.sv
logic/argmax_scan.sv
logic/fc_row.sv
tests/tb_fc_row.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fc_row testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_fc_row -f src.f -o sim_fc_row
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_fc_row)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
